// File: channel_ctrl.f
+incdir+verilog
verilog/channel_pkg.sv
verilog/event_fifo_if.sv
verilog/trigger_qualifier.sv
verilog/sar_sequencer.sv
verilog/csa_reset_timer.sv
verilog/event_builder.sv
verilog/local_fifo.sv
verilog/channel_ctrl.sv
testbench/tb_channel_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the channel controller testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f channel_ctrl.f --top-module tb_channel_ctrl -o tb_channel_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_channel_ctrl > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$log"; then
    exit 0
fi
exit 1

// File: testbench/tb_channel_ctrl.sv
// tb_channel_ctrl: clock, reset, comparator model, stimulus table, event and csa reset checks
`timescale 1ns/1ps

module tb_channel_ctrl;

    localparam int NUM_ROWS = 12;
    localparam int RESET_LEN = 5;
    localparam logic [7:0] CHIP_ID = 8'h5a;
    localparam logic [5:0] CHANNEL_ID = 6'h2b;

    typedef struct packed {
        logic [7:0]  level;       // analog level seen by the comparator
        logic [3:0]  src;         // hit, external, cross, periodic
        logic [3:0]  masks;       // channel, external, cross, periodic
        logic        veto;
        logic [7:0]  threshold;
        logic [15:0] hold;
        logic [31:0] ts;
        logic [1:0]  shared;      // shared fifo full, half
        logic        fires;       // a conversion runs
        logic        has_event;
        logic [1:0]  exp_type;
    } row_t;

    logic clk;
    logic reset_n;
    logic hit, external_trigger, cross_trigger, periodic_trigger;
    logic channel_mask, external_trigger_mask, cross_trigger_mask, periodic_trigger_mask;
    logic enable_periodic_trigger_veto;
    logic comp;
    channel_pkg::chip_id_t    chip_id;
    channel_pkg::channel_id_t channel_id;
    channel_pkg::hold_count_t adc_hold_delay;
    channel_pkg::timestamp_t  timestamp_32b;
    channel_pkg::reset_len_t  reset_length;
    channel_pkg::adc_code_t   digital_threshold;
    logic fifo_full, fifo_half, read_local_fifo_n;
    channel_pkg::event_t      channel_event;
    channel_pkg::adc_code_t   dac_word;
    logic fifo_empty, triggered_natural, csa_reset, sample;

    logic [7:0]  level;
    logic [31:0] seed;
    row_t        table_rows [NUM_ROWS];
    int          errors;
    int          timeouts;

    assign comp = (level >= dac_word);   // ideal comparator

    channel_ctrl channel_ctrl_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic tick();
        @(posedge clk);
        #2;                              // inputs change here, outputs already settled
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic channel_pkg::event_t expected_event(input logic [7:0] code,
            input logic [1:0] ttype, input logic [31:0] ts, input logic [1:0] shared,
            input logic lfull, input logic lhalf);
        channel_pkg::event_t ev;
        ev = '0;
        ev[1:0]   = 2'b01;               // data packet
        ev[9:2]   = CHIP_ID;
        ev[15:10] = CHANNEL_ID;
        ev[43:16] = ts[27:0];
        ev[55:46] = {2'b00, code};
        ev[57:56] = ttype;
        ev[59:58] = shared;
        ev[61:60] = {lfull, lhalf};
        ev[62]    = 1'b1;
        return ev;
    endfunction

    task automatic wait_for_sample(input logic want, input int limit);
        int n;
        n = 0;
        while (sample !== want && n < limit) begin
            tick();
            n++;
        end
        if (sample !== want) begin
            timeouts++;
            $display("sample did not go to %0b within %0d cycles at %0t", want, limit, $time);
        end
    endtask

    task automatic pop_and_compare(input channel_pkg::event_t exp, input string name);
        int n;
        n = 0;
        while (fifo_empty && n < 8) begin
            tick();
            n++;
        end
        if (fifo_empty) begin
            timeouts++;
            $display("no event arrived in the local FIFO for %s at %0t", name, $time);
        end else begin
            if (channel_event !== exp)
                report_mismatch(name, channel_event, exp);
            read_local_fifo_n = 1'b0;    // pop one entry
            tick();
            read_local_fifo_n = 1'b1;
        end
    endtask

    ////////////////////
    // one table row
    ////////////////////
    task automatic run_row(input int idx, input row_t r);
        int n;
        int csa_cycles;
        n = 0;
        csa_cycles = 0;
        if (dac_word !== 8'h80)
            report_mismatch($sformatf("dac_word idle row %0d", idx), dac_word, 8'h80);
        if (sample !== 1'b1)
            report_mismatch($sformatf("sample idle row %0d", idx), sample, 1);
        level = r.level;
        digital_threshold = r.threshold;
        adc_hold_delay = r.hold;
        timestamp_32b = r.ts;
        {fifo_full, fifo_half} = r.shared;
        {channel_mask, external_trigger_mask, cross_trigger_mask, periodic_trigger_mask} = r.masks;
        enable_periodic_trigger_veto = r.veto;
        {hit, external_trigger, cross_trigger, periodic_trigger} = r.src;
        #1;                              // qualifier output settles
        if (triggered_natural !== (r.src[3] & ~r.masks[3]))
            report_mismatch($sformatf("triggered_natural row %0d", idx), triggered_natural,
                            r.src[3] & ~r.masks[3]);
        tick();                          // accepting edge
        {hit, external_trigger, cross_trigger, periodic_trigger} = 4'b0000;
        while (fifo_empty && n < r.hold + 20) begin
            if (csa_reset)
                csa_cycles++;
            tick();
            n++;
        end
        if (r.has_event && fifo_empty) begin
            timeouts++;
            $display("row %0d wrote no event within %0d cycles", idx, r.hold + 20);
        end
        if (!r.has_event && !fifo_empty)
            report_mismatch($sformatf("fifo_empty row %0d", idx), fifo_empty, 1);
        // write edge is hold+13, the flag follows one edge later
        if (!fifo_empty && n != r.hold + 14)
            report_mismatch($sformatf("write latency row %0d", idx), n, r.hold + 14);
        if (csa_cycles != (r.fires ? RESET_LEN : 0))
            report_mismatch($sformatf("csa_reset cycles row %0d", idx), csa_cycles,
                            r.fires ? RESET_LEN : 0);
        if (!fifo_empty) begin
            pop_and_compare(expected_event(r.level, r.exp_type, r.ts, r.shared, 1'b0, 1'b0),
                            $sformatf("channel_event row %0d", idx));
            if (fifo_empty !== 1'b1)
                report_mismatch($sformatf("fifo_empty after pop row %0d", idx), fifo_empty, 1);
        end
        {channel_mask, external_trigger_mask, cross_trigger_mask, periodic_trigger_mask} = 4'h0;
        enable_periodic_trigger_veto = 1'b0;
    endtask

    ////////////////////
    // back-pressure
    ////////////////////
    task automatic fill_and_drain();
        channel_pkg::event_t expected_q[$];
        logic [31:0] ts;
        digital_threshold = 8'h00;
        adc_hold_delay = 16'd0;
        {fifo_full, fifo_half} = 2'b01;
        for (int i = 0; i < 9; i++) begin
            seed = lcg_next(seed);
            level = seed[23:16];
            seed = lcg_next(seed);
            ts = seed;
            timestamp_32b = ts;
            hit = 1'b1;
            tick();
            hit = 1'b0;
            // entry i is built with i entries stored, the ninth after one pop
            expected_q.push_back(expected_event(level, 2'd0, ts, 2'b01, 1'b0, i >= 4));
            wait_for_sample(1'b0, 6);
            wait_for_sample(1'b1, 12);
            if (i < 8)
                repeat (4) tick();       // sar done, request, transfer, write
        end
        repeat (6) tick();               // ninth waits on the full FIFO
        for (int i = 0; i < 9; i++)
            pop_and_compare(expected_q.pop_front(), $sformatf("channel_event fill %0d", i));
        if (fifo_empty !== 1'b1)
            report_mismatch("fifo_empty after drain", fifo_empty, 1);
    endtask

    initial begin
        int n;
        int high;
        {hit, external_trigger, cross_trigger, periodic_trigger} = 4'b0000;
        {channel_mask, external_trigger_mask, cross_trigger_mask, periodic_trigger_mask} = 4'h0;
        enable_periodic_trigger_veto = 1'b0;
        chip_id = CHIP_ID;
        channel_id = CHANNEL_ID;
        adc_hold_delay = '0;
        timestamp_32b = '0;
        reset_length = 8'(RESET_LEN);
        digital_threshold = '0;
        {fifo_full, fifo_half} = 2'b00;
        read_local_fifo_n = 1'b1;
        level = 8'h00;
        seed = 32'hbcb4_c084;
        errors = 0;
        timeouts = 0;

        //   level  src      masks    veto thr hold ts        shared fires event type
        table_rows[0] = '{8'hc3, 4'b1000, 4'b0000, 0, 8'h40, 2, 32'hf123_4567, 2'b00, 1, 1, 0};
        table_rows[1] = '{8'h40, 4'b1000, 4'b0000, 0, 8'h40, 0, 32'h0000_0001, 2'b11, 1, 1, 0};
        table_rows[2] = '{8'h7e, 4'b0100, 4'b0000, 0, 8'h00, 5, 32'h8abc_def0, 2'b10, 1, 1, 1};
        table_rows[3] = '{8'hff, 4'b0010, 4'b0000, 0, 8'h10, 1, 32'h0fff_ffff, 2'b01, 1, 1, 2};
        table_rows[4] = '{8'h01, 4'b0001, 4'b0000, 0, 8'h00, 3, 32'h1234_5678, 2'b00, 1, 1, 3};
        table_rows[5] = '{8'h99, 4'b1100, 4'b0000, 0, 8'h00, 0, 32'h5555_aaaa, 2'b00, 1, 1, 0};
        table_rows[6] = '{8'h80, 4'b0100, 4'b0100, 0, 8'h00, 1, 32'h0000_0100, 2'b00, 0, 0, 0};
        table_rows[7] = '{8'h80, 4'b1000, 4'b1000, 0, 8'h00, 1, 32'h0000_0200, 2'b00, 0, 0, 0};
        table_rows[8] = '{8'h80, 4'b0001, 4'b0001, 0, 8'h00, 1, 32'h0000_0300, 2'b00, 0, 0, 0};
        table_rows[9] = '{8'h5c, 4'b1001, 4'b0000, 1, 8'h00, 2, 32'h3c3c_3c3c, 2'b10, 1, 1, 0};
        table_rows[10] = '{8'h3f, 4'b1000, 4'b0000, 0, 8'h40, 0, 32'h0000_0400, 2'b00, 1, 0, 0};
        table_rows[11] = '{8'h23, 4'b0011, 4'b0000, 0, 8'h00, 4, 32'hdead_0123, 2'b01, 1, 1, 0};

        reset_n = 1'b0;
        repeat (3) tick();
        reset_n = 1'b1;
        if (fifo_empty !== 1'b1) report_mismatch("fifo_empty after reset", fifo_empty, 1);
        if (sample !== 1'b1) report_mismatch("sample after reset", sample, 1);
        if (dac_word !== 8'h80) report_mismatch("dac_word after reset", dac_word, 8'h80);

        // reset asks for one CSA reset pulse
        n = 0;
        while (!csa_reset && n < 4) begin
            tick();
            n++;
        end
        if (!csa_reset) begin
            timeouts++;
            $display("csa_reset did not rise after reset");
        end
        high = 0;
        while (csa_reset && high <= RESET_LEN + 2) begin
            high++;
            tick();
        end
        if (high != RESET_LEN) report_mismatch("csa_reset cycles after reset", high, RESET_LEN);

        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i, table_rows[i]);
        fill_and_drain();

        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog/channel_ctrl.sv
// channel_ctrl: per-channel controller top level with trigger, SAR, reset and FIFO blocks
`timescale 1ns/1ps

module channel_ctrl (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     hit,
    input  logic                     external_trigger,
    input  logic                     cross_trigger,
    input  logic                     periodic_trigger,
    input  logic                     channel_mask,
    input  logic                     external_trigger_mask,
    input  logic                     cross_trigger_mask,
    input  logic                     periodic_trigger_mask,
    input  logic                     enable_periodic_trigger_veto,
    input  logic                     comp,
    input  channel_pkg::chip_id_t    chip_id,
    input  channel_pkg::channel_id_t channel_id,
    input  channel_pkg::hold_count_t adc_hold_delay,
    input  channel_pkg::timestamp_t  timestamp_32b,
    input  channel_pkg::reset_len_t  reset_length,
    input  channel_pkg::adc_code_t   digital_threshold,
    input  logic                     fifo_full,
    input  logic                     fifo_half,
    input  logic                     read_local_fifo_n,
    output channel_pkg::event_t      channel_event,
    output channel_pkg::adc_code_t   dac_word,
    output logic                     fifo_empty,
    output logic                     triggered_natural,
    output logic                     csa_reset,
    output logic                     sample
);

    logic                       idle;
    logic                       triggered;
    logic                       reset_request;
    logic                       build;
    channel_pkg::trigger_type_t trigger_type;
    channel_pkg::trigger_type_t trigger_type_latched;
    channel_pkg::adc_code_t     adc_code;
    channel_pkg::timestamp_t    timestamp_latched;

    event_fifo_if fifo_bus ();

    trigger_qualifier trigger_qualifier_inst (
        .hit, .external_trigger, .cross_trigger, .periodic_trigger,
        .channel_mask, .external_trigger_mask, .cross_trigger_mask,
        .periodic_trigger_mask, .enable_periodic_trigger_veto,
        .idle, .triggered, .trigger_type, .triggered_natural
    );

    sar_sequencer sar_sequencer_inst (
        .clk, .reset_n, .triggered, .trigger_type, .comp, .adc_hold_delay,
        .timestamp_32b, .fifo(fifo_bus.monitor), .idle, .sample, .reset_request,
        .build, .dac_word, .adc_code, .timestamp_latched, .trigger_type_latched
    );

    csa_reset_timer csa_reset_timer_inst (
        .clk, .reset_n, .reset_request, .reset_length, .csa_reset
    );

    event_builder event_builder_inst (
        .clk, .reset_n, .build, .adc_code, .timestamp_latched, .trigger_type_latched,
        .chip_id, .channel_id, .digital_threshold, .fifo_full, .fifo_half,
        .fifo(fifo_bus.writer)
    );

    local_fifo local_fifo_inst (
        .clk, .reset_n, .read_local_fifo_n, .fifo(fifo_bus.storage),
        .channel_event, .fifo_empty
    );

endmodule

// File: verilog/local_fifo.sv
// local_fifo: flip-flop derandomizing FIFO with count, full, half and empty flags
`timescale 1ns/1ps
`include "channel_macros.svh"

module local_fifo (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                read_local_fifo_n,   // low pops the head
    event_fifo_if.storage       fifo,
    output channel_pkg::event_t channel_event,
    output logic                fifo_empty
);

    channel_pkg::event_t         mem [`LOCAL_FIFO_DEPTH];
    logic [`LOCAL_FIFO_BITS-1:0] wr_ptr;
    logic [`LOCAL_FIFO_BITS-1:0] rd_ptr;
    channel_pkg::fifo_count_t    count;
    logic                        do_write;
    logic                        do_read;

    always_comb begin
        fifo.local_full = (count == channel_pkg::fifo_count_t'(`LOCAL_FIFO_DEPTH));
        fifo.local_half = (count >= channel_pkg::fifo_count_t'(`LOCAL_FIFO_DEPTH / 2));
        fifo_empty      = (count == '0);
        do_write        = !fifo.write_n && !fifo.local_full;   // dropped when full
        do_read         = !read_local_fifo_n && !fifo_empty;
        channel_event   = mem[rd_ptr];                         // head entry
    end

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= fifo.event_data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // the sequencer should hold off on full, so this is a lost event
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        !(!fifo.write_n && fifo.local_full))
        else $error("event written to a full local FIFO");

endmodule

// File: verilog/event_builder.sv
// event_builder: event word packing and thresholded write to the local FIFO
`timescale 1ns/1ps
`include "channel_macros.svh"

module event_builder (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       build,
    input  channel_pkg::adc_code_t     adc_code,
    input  channel_pkg::timestamp_t    timestamp_latched,
    input  channel_pkg::trigger_type_t trigger_type_latched,
    input  channel_pkg::chip_id_t      chip_id,
    input  channel_pkg::channel_id_t   channel_id,
    input  channel_pkg::adc_code_t     digital_threshold,
    input  logic                       fifo_full,    // shared FIFO flags
    input  logic                       fifo_half,
    event_fifo_if.writer               fifo
);

    // packed msb first, see the layout in channel_pkg
    always_ff @(posedge clk) begin
        if (build) begin
            fifo.event_data <= {1'b1,
                                fifo.local_full, fifo.local_half,
                                fifo_full, fifo_half,
                                trigger_type_latched,
                                2'b00, adc_code,          // 10 bit adc field
                                2'b00,
                                timestamp_latched[`TS_BITS-1:0],
                                channel_id,
                                chip_id,
                                2'b01};                   // data packet
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            fifo.write_n <= 1'b1;
        else
            fifo.write_n <= !(build && (adc_code >= digital_threshold));   // single cycle
    end

endmodule

// File: verilog/csa_reset_timer.sv
// csa_reset_timer: CSA reset pulse of programmable length after each request
`timescale 1ns/1ps

module csa_reset_timer (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    reset_request,
    input  channel_pkg::reset_len_t reset_length,
    output logic                    csa_reset
);

    channel_pkg::reset_len_t reset_count;   // cycles still to hold
    channel_pkg::reset_len_t high_cycles;   // cycles held since the last load
    logic                    power_on;      // chip reset asks for one pulse
    logic                    load;

    assign load      = reset_request | power_on;
    assign csa_reset = (reset_count != '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            power_on    <= 1'b1;
            reset_count <= '0;
            high_cycles <= '0;
        end else begin
            power_on <= 1'b0;
            if (load) begin
                reset_count <= reset_length;   // zero length gives no pulse
                high_cycles <= '0;
            end else if (csa_reset) begin
                reset_count <= reset_count - 1'b1;
                high_cycles <= high_cycles + 1'b1;
            end
        end
    end

    a_reset_length: assert property (@(posedge clk) disable iff (!reset_n)
        csa_reset |-> (high_cycles < reset_length))
        else $error("csa_reset held past reset_length");

endmodule

// File: verilog/sar_sequencer.sv
// sar_sequencer: channel FSM, SAR mask and code registers, DAC word, sample and latches
`timescale 1ns/1ps
`include "channel_macros.svh"

module sar_sequencer (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       triggered,
    input  channel_pkg::trigger_type_t trigger_type,
    input  logic                       comp,
    input  channel_pkg::hold_count_t   adc_hold_delay,
    input  channel_pkg::timestamp_t    timestamp_32b,
    event_fifo_if.monitor              fifo,
    output logic                       idle,
    output logic                       sample,
    output logic                       reset_request,
    output logic                       build,
    output channel_pkg::adc_code_t     dac_word,
    output channel_pkg::adc_code_t     adc_code,
    output channel_pkg::timestamp_t    timestamp_latched,
    output channel_pkg::trigger_type_t trigger_type_latched
);

    channel_pkg::chan_state_t state;
    channel_pkg::chan_state_t next_state;
    channel_pkg::adc_code_t   sar_mask;         // bit under test
    channel_pkg::hold_count_t sample_counter;
    logic                     readout_mode;     // dac parked at midscale

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        next_state = state;
        case (state)
            channel_pkg::IDLE: begin
                if (triggered)
                    next_state = channel_pkg::SAMPLE;
            end
            channel_pkg::SAMPLE: begin
                if (sample_counter >= adc_hold_delay)
                    next_state = channel_pkg::RESET_CSA;
            end
            channel_pkg::RESET_CSA:
                next_state = channel_pkg::CONVERT;
            channel_pkg::CONVERT: begin
                if (sar_mask[0])                 // lsb decided on this edge
                    next_state = channel_pkg::SAR_DONE;
            end
            channel_pkg::SAR_DONE:
                next_state = channel_pkg::REQUEST_READOUT;
            channel_pkg::REQUEST_READOUT: begin
                if (!fifo.local_full)            // wait here while the FIFO is full
                    next_state = channel_pkg::TRANSFER;
            end
            default:
                next_state = channel_pkg::IDLE;
        endcase
    end

    always_comb begin
        idle          = (state == channel_pkg::IDLE);
        reset_request = (state == channel_pkg::RESET_CSA);
        build         = (state == channel_pkg::TRANSFER);
        readout_mode  = (state == channel_pkg::REQUEST_READOUT) || build;
        dac_word      = readout_mode ? `SAR_START_MASK : (adc_code | sar_mask);
    end

    ////////////////////
    // state and SAR
    ////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= channel_pkg::IDLE;
            sar_mask       <= `SAR_START_MASK;
            adc_code       <= '0;
            sample_counter <= '0;
            sample         <= 1'b1;
        end else begin
            state  <= next_state;
            sample <= (next_state != channel_pkg::RESET_CSA)
                      && (next_state != channel_pkg::CONVERT);   // hold only during conversion
            case (state)
                channel_pkg::SAMPLE:
                    sample_counter <= sample_counter + 1'b1;
                channel_pkg::CONVERT: begin
                    if (comp)
                        adc_code <= adc_code | sar_mask;   // keep the tested bit
                    sar_mask <= sar_mask >> 1;
                end
                channel_pkg::IDLE, channel_pkg::TRANSFER: begin
                    sar_mask       <= `SAR_START_MASK;
                    adc_code       <= '0;   // builder samples the old code on this edge
                    sample_counter <= '0;
                end
                default: ;
            endcase
        end
    end

    // grabbed on the accepting edge
    always_ff @(posedge clk) begin
        if (idle && triggered) begin
            timestamp_latched    <= timestamp_32b;
            trigger_type_latched <= trigger_type;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!reset_n)
        state inside {channel_pkg::IDLE, channel_pkg::SAMPLE, channel_pkg::RESET_CSA,
                      channel_pkg::CONVERT, channel_pkg::SAR_DONE,
                      channel_pkg::REQUEST_READOUT, channel_pkg::TRANSFER})
        else $error("channel state left the enum");

endmodule

// File: verilog/trigger_qualifier.sv
// trigger_qualifier: source masking, periodic veto and trigger type encoding
`timescale 1ns/1ps

module trigger_qualifier (
    input  logic                       hit,
    input  logic                       external_trigger,
    input  logic                       cross_trigger,
    input  logic                       periodic_trigger,
    input  logic                       channel_mask,
    input  logic                       external_trigger_mask,
    input  logic                       cross_trigger_mask,
    input  logic                       periodic_trigger_mask,
    input  logic                       enable_periodic_trigger_veto,
    input  logic                       idle,
    output logic                       triggered,
    output channel_pkg::trigger_type_t trigger_type,
    output logic                       triggered_natural
);

    logic triggered_external;
    logic triggered_cross;
    logic triggered_periodic;

    // a masked channel ignores every source
    always_comb begin
        triggered_natural  = hit & ~channel_mask;
        triggered_external = external_trigger & ~external_trigger_mask & ~channel_mask;
        triggered_cross    = cross_trigger & ~cross_trigger_mask & ~channel_mask;
        triggered_periodic = periodic_trigger & ~periodic_trigger_mask & ~channel_mask
                             & ~(hit & enable_periodic_trigger_veto) & idle;
        triggered = triggered_natural | triggered_external | triggered_cross
                    | triggered_periodic;

        case ({triggered_natural, triggered_external, triggered_cross, triggered_periodic})
            4'b0100: trigger_type = 2'd1;   // external
            4'b0010: trigger_type = 2'd2;   // cross
            4'b0001: trigger_type = 2'd3;   // periodic
            default: trigger_type = 2'd0;   // natural, or several at once
        endcase
    end

endmodule

// File: verilog/event_fifo_if.sv
// event_fifo_if: event write path and fill flags of the local FIFO
`timescale 1ns/1ps

interface event_fifo_if;

    channel_pkg::event_t event_data;   // event to store
    logic                write_n;      // low to write on this edge
    logic                local_full;
    logic                local_half;   // four or more entries

    modport writer  (output event_data, output write_n, input local_full, input local_half);
    modport storage (input event_data, input write_n, output local_full, output local_half);
    modport monitor (input local_full);

endinterface

// File: verilog/channel_pkg.sv
// channel_pkg: vector typedefs, event word layout and controller state enum
`include "channel_macros.svh"

package channel_pkg;

    // event word, lsb first
    //   1:0   01 data packet       9:2   chip_id
    //   15:10 channel_id           43:16 timestamp[27:0]
    //   45:44 00                   55:46 adc code, zero extended
    //   57:56 trigger type         59:58 shared fifo full, half
    //   61:60 local full, half     62    always 1
    typedef logic [`EVENT_WIDTH-1:0]     event_t;
    typedef logic [`ADC_BITS-1:0]        adc_code_t;    // conversion result and dac word
    typedef logic [7:0]                  chip_id_t;
    typedef logic [5:0]                  channel_id_t;
    typedef logic [31:0]                 timestamp_t;   // free running input timestamp
    typedef logic [1:0]                  trigger_type_t; // 0 natural, 1 ext, 2 cross, 3 periodic
    typedef logic [15:0]                 hold_count_t;
    typedef logic [7:0]                  reset_len_t;
    typedef logic [`LOCAL_FIFO_BITS:0]   fifo_count_t;  // one extra bit for full

    ////////////////////
    // controller states
    ////////////////////
    typedef enum logic [2:0] {
        IDLE            = 3'h0,
        SAMPLE          = 3'h1,
        RESET_CSA       = 3'h2,
        CONVERT         = 3'h3,
        SAR_DONE        = 3'h4,
        REQUEST_READOUT = 3'h5,
        TRANSFER        = 3'h6
    } chan_state_t;

endpackage

// File: verilog/channel_macros.svh
// widths, depths and reset constants for the channel controller
`ifndef CHANNEL_MACROS_SVH
`define CHANNEL_MACROS_SVH

////////////////////
// word widths
////////////////////
`define EVENT_WIDTH 63        // packet without start and stop bits
`define ADC_BITS 8            // SAR resolution
`define TS_BITS 28            // timestamp bits kept in the event

////////////////////
// local FIFO
////////////////////
`define LOCAL_FIFO_DEPTH 8
`define LOCAL_FIFO_BITS 3     // address width

// first bit tested by the SAR, also the idle DAC word
`define SAR_START_MASK 8'h80

`endif
